//--- bench/periph_top_tb.sv
/*
 Table-driven testbench for periph_top, one bus request per table entry.
 Expected values come from a model of the register map that is updated while
 the table is built. DSP operands are random with a fixed seed.
*/
`timescale 1ns/1ps

module periph_top_tb;

    localparam int MAX_ENTRIES = 64;
    localparam int CYCLES_PER_REQUEST = 4;
    localparam int EXPECTED_LATENCY = 2;
    localparam int RESET_CYCLES = 3;

    logic vdp_clk;
    logic vdp_reset;
    logic cpu_mem_valid;
    soc_pkg::addr_t cpu_address;
    soc_pkg::wstrb_t cpu_wstrb;
    soc_pkg::data_t cpu_write_data;
    soc_pkg::pad_data_t pad_data;
    soc_pkg::nibble_t flash_out;
    soc_pkg::data_t cpu_read_data;
    logic cpu_mem_ready;
    soc_pkg::led_t led;
    logic pad_latch;
    logic pad_clk;
    logic flash_clk;
    logic flash_csn;
    soc_pkg::nibble_t flash_in;
    soc_pkg::nibble_t flash_in_en;

    // Stimulus table
    logic               tbl_write [MAX_ENTRIES];
    soc_pkg::addr_t     tbl_addr [MAX_ENTRIES];
    soc_pkg::wstrb_t    tbl_wstrb [MAX_ENTRIES];
    soc_pkg::data_t     tbl_wdata [MAX_ENTRIES];
    soc_pkg::pad_data_t tbl_pad [MAX_ENTRIES];
    soc_pkg::nibble_t   tbl_fout [MAX_ENTRIES];
    soc_pkg::data_t     tbl_exp_rdata [MAX_ENTRIES];
    soc_pkg::led_t      tbl_exp_led [MAX_ENTRIES];
    logic               tbl_exp_latch [MAX_ENTRIES];
    logic               tbl_exp_pclk [MAX_ENTRIES];
    logic               tbl_exp_fclk [MAX_ENTRIES];
    logic               tbl_exp_fcsn [MAX_ENTRIES];
    soc_pkg::nibble_t   tbl_exp_fin [MAX_ENTRIES];
    soc_pkg::nibble_t   tbl_exp_fen [MAX_ENTRIES];
    int num_entries;

    // Register map model
    soc_pkg::led_t model_led;
    soc_pkg::operand_t model_op_a;
    soc_pkg::operand_t model_op_b;
    logic model_latch;
    logic model_pclk;
    logic model_fclk;
    logic model_fcsn;
    soc_pkg::nibble_t model_fin;
    soc_pkg::nibble_t model_fen;

    integer seed;
    int cycle_count = 0;
    int timeout_limit;

    periph_top UUT (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_address(cpu_address),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .pad_data(pad_data),
        .flash_out(flash_out),
        .cpu_read_data(cpu_read_data),
        .cpu_mem_ready(cpu_mem_ready),
        .led(led),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #50 vdp_clk = ~vdp_clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(input string what, input soc_pkg::data_t actual,
                              input soc_pkg::data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_led(input string what, input soc_pkg::led_t actual,
                             input soc_pkg::led_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_nibble(input string what, input soc_pkg::nibble_t actual,
                                input soc_pkg::nibble_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_bit(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_latency(input string what, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("Mismatch at %0t: %s got %0d cycles, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    function automatic soc_pkg::data_t signed_product(input soc_pkg::operand_t a,
                                                      input soc_pkg::operand_t b);
        logic signed [15:0] sa;
        logic signed [15:0] sb;
        logic signed [31:0] p;
        sa = a;
        sb = b;
        p = sa * sb;
        return p;
    endfunction

    task automatic store_entry(input logic is_write, input soc_pkg::addr_t addr,
                               input soc_pkg::wstrb_t strb, input soc_pkg::data_t data,
                               input soc_pkg::pad_data_t pad, input soc_pkg::nibble_t fout,
                               input soc_pkg::data_t exp_rdata);
        tbl_write[num_entries] = is_write;
        tbl_addr[num_entries] = addr;
        tbl_wstrb[num_entries] = strb;
        tbl_wdata[num_entries] = data;
        tbl_pad[num_entries] = pad;
        tbl_fout[num_entries] = fout;
        tbl_exp_rdata[num_entries] = exp_rdata;
        tbl_exp_led[num_entries] = model_led;
        tbl_exp_latch[num_entries] = model_latch;
        tbl_exp_pclk[num_entries] = model_pclk;
        tbl_exp_fclk[num_entries] = model_fclk;
        tbl_exp_fcsn[num_entries] = model_fcsn;
        tbl_exp_fin[num_entries] = model_fin;
        tbl_exp_fen[num_entries] = model_fen;
        num_entries++;
    endtask

    // Region from address bits 23:20 and operand B on bit 2
    task automatic add_write(input soc_pkg::addr_t addr, input soc_pkg::wstrb_t strb,
                             input soc_pkg::data_t data);
        case (addr[23:20])
            4'd1: model_led = data[7:0];
            4'd2: begin
                if (addr[2]) begin
                    model_op_b = data[15:0];
                end else begin
                    model_op_a = data[15:0];
                end
            end
            4'd3: begin
                model_latch = data[0];
                model_pclk = data[1];
            end
            4'd4: begin
                // Pins idle unless active bit 15 is set
                model_fclk = data[15] ? data[8] : 1'b0;
                model_fcsn = data[15] ? data[9] : 1'b1;
                model_fin = data[15] ? data[3:0] : 4'h0;
                model_fen = data[15] ? data[7:4] : 4'h0;
            end
            default: begin
            end
        endcase
        store_entry(1'b1, addr, strb, data, 2'b00, 4'h0, 32'h0);
    endtask

    task automatic add_read(input soc_pkg::addr_t addr, input soc_pkg::pad_data_t pad,
                            input soc_pkg::nibble_t fout);
        soc_pkg::data_t expected;
        case (addr[23:20])
            4'd2: expected = signed_product(model_op_a, model_op_b);
            4'd3: expected = {30'h0, pad};
            4'd4: expected = {28'h0, fout};
            default: expected = 32'h0;
        endcase
        store_entry(1'b0, addr, 4'b0000, 32'h0, pad, fout, expected);
    endtask

    task automatic build_table();
        soc_pkg::data_t word_a;
        soc_pkg::data_t word_b;
        num_entries = 0;
        model_led = 8'h00;
        model_op_a = 16'h0;
        model_op_b = 16'h0;
        model_latch = 1'b0;
        model_pclk = 1'b0;
        model_fclk = 1'b0;
        model_fcsn = 1'b1;
        model_fin = 4'h0;
        model_fen = 4'h0;

        // Unmapped and status accesses
        add_read(24'h000000, 2'b11, 4'hF);
        add_write(24'hF00010, 4'b1111, 32'hDEAD_BEEF);
        add_write(24'h100000, 4'b1111, 32'h1234_5AA5);
        add_read(24'h100000, 2'b00, 4'h0);

        // Gamepad
        add_write(24'h300000, 4'b0001, 32'hFFFF_FF03);
        add_read(24'h300000, 2'b10, 4'h0);
        add_write(24'h300000, 4'b0001, 32'h0000_0002);
        add_read(24'h300008, 2'b01, 4'h0);

        // Flash port active then idle
        add_write(24'h400000, 4'b0011, 32'h0000_81FA);
        add_read(24'h400000, 2'b00, 4'h6);
        add_write(24'h400000, 4'b0011, 32'h0000_8035);
        add_write(24'h400000, 4'b0011, 32'h0000_03FF);
        add_read(24'h400000, 2'b00, 4'h9);
        add_write(24'h100000, 4'b0010, 32'h0000_0055);

        for (int k = 0; k < 5; k++) begin
            word_a = $random(seed);
            word_b = $random(seed);
            add_write(24'h200000, 4'b0011, word_a);
            add_write(24'h200004, 4'b0011, word_b);
            add_read(24'h200000, 2'b00, 4'h0);
        end

        // Most negative operands
        add_write(24'h200000, 4'b0011, 32'h0000_8000);
        add_write(24'h200004, 4'b0011, 32'h0000_8000);
        add_read(24'h200004, 2'b00, 4'h0);
        add_read(24'hF00000, 2'b00, 4'h0);
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic run_request(input int idx);
        int latency;
        string tag;
        tag = $sformatf("entry %0d", idx);
        cpu_address = tbl_addr[idx];
        cpu_wstrb = tbl_wstrb[idx];
        cpu_write_data = tbl_wdata[idx];
        pad_data = tbl_pad[idx];
        flash_out = tbl_fout[idx];
        cpu_mem_valid = 1'b1;
        latency = 0;
        @(posedge vdp_clk);
        #1;
        while (!cpu_mem_ready) begin
            @(posedge vdp_clk);
            #1;
            latency++;
        end
        cpu_mem_valid = 1'b0;

        check_latency({tag, " ready latency"}, latency, EXPECTED_LATENCY);
        if (!tbl_write[idx]) begin
            check_data({tag, " read data"}, cpu_read_data, tbl_exp_rdata[idx]);
        end
        check_led({tag, " led"}, led, tbl_exp_led[idx]);
        check_bit({tag, " pad_latch"}, pad_latch, tbl_exp_latch[idx]);
        check_bit({tag, " pad_clk"}, pad_clk, tbl_exp_pclk[idx]);
        check_bit({tag, " flash_clk"}, flash_clk, tbl_exp_fclk[idx]);
        check_bit({tag, " flash_csn"}, flash_csn, tbl_exp_fcsn[idx]);
        check_nibble({tag, " flash_in"}, flash_in, tbl_exp_fin[idx]);
        check_nibble({tag, " flash_in_en"}, flash_in_en, tbl_exp_fen[idx]);

        // Ready lasts one cycle
        @(posedge vdp_clk);
        #1;
        check_bit({tag, " ready one cycle later"}, cpu_mem_ready, 1'b0);
    endtask

    always @(posedge vdp_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            abort_run($sformatf("Timeout: ready never came within %0d cycles",
                                timeout_limit));
        end
    end

    initial begin
        seed = 17;
        vdp_reset = 1'b1;
        cpu_mem_valid = 1'b0;
        cpu_address = '0;
        cpu_wstrb = '0;
        cpu_write_data = '0;
        pad_data = '0;
        flash_out = '0;
        build_table();
        timeout_limit = num_entries * CYCLES_PER_REQUEST + 20;

        repeat (RESET_CYCLES) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;

        check_led("reset led", led, 8'h00);
        check_bit("reset pad_latch", pad_latch, 1'b0);
        check_bit("reset pad_clk", pad_clk, 1'b0);
        check_bit("reset flash_csn", flash_csn, 1'b1);
        check_bit("reset flash_clk", flash_clk, 1'b0);
        check_nibble("reset flash_in_en", flash_in_en, 4'h0);
        check_nibble("reset flash_in", flash_in, 4'h0);
        check_bit("reset cpu_mem_ready", cpu_mem_ready, 1'b0);

        for (int i = 0; i < num_entries; i++) begin
            run_request(i);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- src/address_decoder.sv
/*
 Registers a held CPU request and issues one access pulse per request.
 The master must hold valid, address, strobes and data until ready.
 Only one request is in flight; valid is ignored until ready has been seen.
*/
`timescale 1ns/1ps

module address_decoder (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    input  logic                cpu_mem_valid,
    input  soc_pkg::addr_t      cpu_address,
    input  soc_pkg::wstrb_t     cpu_wstrb,
    input  soc_pkg::data_t      cpu_write_data,
    input  logic                cpu_mem_ready,
    periph_bus_if.decoder       bus
);

    typedef enum logic {
        STATE_IDLE,
        STATE_BUSY
    } state_t;

    state_t state;
    logic launch;

    soc_pkg::addr_t address_q;
    soc_pkg::wstrb_t wstrb_q;
    soc_pkg::data_t write_data_q;

    function automatic soc_pkg::region_t decode_region(input logic [3:0] nibble);
        case (nibble)
            soc_pkg::REGION_NIBBLE_STATUS: return soc_pkg::REGION_STATUS;
            soc_pkg::REGION_NIBBLE_DSP:    return soc_pkg::REGION_DSP;
            soc_pkg::REGION_NIBBLE_PAD:    return soc_pkg::REGION_PAD;
            soc_pkg::REGION_NIBBLE_FLASH:  return soc_pkg::REGION_FLASH_CTRL;
            default:                       return soc_pkg::REGION_NONE;
        endcase
    endfunction

    // Idle until a request arrives, busy until its ready pulse
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= STATE_IDLE;
            launch <= 1'b0;
        end else begin
            launch <= 1'b0;
            case (state)
                STATE_IDLE: begin
                    if (cpu_mem_valid) begin
                        state <= STATE_BUSY;
                        launch <= 1'b1;
                    end
                end
                STATE_BUSY: begin
                    if (cpu_mem_ready) begin
                        state <= STATE_IDLE;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

    // Request capture
    always_ff @(posedge vdp_clk) begin
        if (state == STATE_IDLE) begin
            address_q <= cpu_address;
            wstrb_q <= cpu_wstrb;
            write_data_q <= cpu_write_data;
        end
    end

    // Any set strobe makes it a write
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            bus.write_en <= 1'b0;
            bus.read_en <= 1'b0;
        end else begin
            bus.write_en <= launch && (|wstrb_q);
            bus.read_en <= launch && !(|wstrb_q);
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (launch) begin
            bus.region <= decode_region(address_q[$bits(soc_pkg::addr_t) - 1 -: 4]);
            bus.operand_b <= address_q[soc_pkg::DSP_OPERAND_B_BIT];
            bus.write_data <= write_data_q;
        end
    end

    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !(bus.read_en && bus.write_en))
        else $error("read_en and write_en both high");

endmodule

//--- src/bus_read_mux.sv
/*
 Registered read data and ready for every decoded access.
 Unmapped and status reads return zero. flash_out is assumed already
 registered at the pad.
*/
`timescale 1ns/1ps

module bus_read_mux (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    periph_bus_if.peripheral    bus,
    input  soc_pkg::product_t   dsp_result,
    input  soc_pkg::pad_data_t  pad_data,
    input  soc_pkg::nibble_t    flash_out,
    output soc_pkg::data_t      cpu_read_data,
    output logic                cpu_mem_ready
);

    soc_pkg::data_t read_data_q;
    logic ready_q;

    // One ready per access including writes
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.write_en || bus.read_en;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (bus.read_en) begin
            case (bus.region)
                soc_pkg::REGION_DSP:        read_data_q <= dsp_result;
                soc_pkg::REGION_PAD:        read_data_q <= soc_pkg::data_t'(pad_data);
                soc_pkg::REGION_FLASH_CTRL: read_data_q <= soc_pkg::data_t'(flash_out);
                default:                    read_data_q <= '0;
            endcase
        end
    end

    assign cpu_read_data = read_data_q;
    assign cpu_mem_ready = ready_q;

    // Decoder stays busy through ready, so no back-to-back ready
    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        cpu_mem_ready |=> !cpu_mem_ready)
        else $error("ready high on two consecutive cycles");

endmodule

//--- src/dsp_mult.sv
/*
 Signed 16x16 multiplier behind two operand registers.
 The product follows the operands one cycle after a write; only the low
 half of the write data is used.
*/
`timescale 1ns/1ps

module dsp_mult (
    input  logic                vdp_clk,
    periph_bus_if.peripheral    bus,
    output soc_pkg::product_t   dsp_result
);

    localparam int OPERAND_WIDTH = $bits(soc_pkg::operand_t);

    // Start from zero at power-up
    soc_pkg::operand_t operand_a = '0;
    soc_pkg::operand_t operand_b = '0;
    soc_pkg::product_t product = '0;

    logic dsp_write;

    assign dsp_write = bus.write_en && (bus.region == soc_pkg::REGION_DSP);

    always_ff @(posedge vdp_clk) begin
        // Operand B on the select bit, operand A otherwise
        if (dsp_write && !bus.operand_b) begin
            operand_a <= bus.write_data[OPERAND_WIDTH - 1:0];
        end

        if (dsp_write && bus.operand_b) begin
            operand_b <= bus.write_data[OPERAND_WIDTH - 1:0];
        end

        product <= $signed(operand_a) * $signed(operand_b);
    end

    assign dsp_result = product;

endmodule

//--- src/flash_ctrl.sv
/*
 CPU bit-bang port for the SPI/QSPI flash pins.
 With the active bit clear the pins idle: CSn high, clock low, lanes undriven.
 Software must not raise the clock while CSn is high.
*/
`timescale 1ns/1ps

module flash_ctrl (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    periph_bus_if.peripheral    bus,
    output logic                flash_clk,
    output logic                flash_csn,
    output soc_pkg::nibble_t    flash_in,
    output soc_pkg::nibble_t    flash_in_en
);

    localparam int NIBBLE_WIDTH = $bits(soc_pkg::nibble_t);

    logic active;
    logic clk_q;
    logic csn_q;
    soc_pkg::nibble_t in_q;
    soc_pkg::nibble_t in_en_q;

    logic ctrl_write;

    assign ctrl_write = bus.write_en && (bus.region == soc_pkg::REGION_FLASH_CTRL);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active <= 1'b0;
        end else if (ctrl_write) begin
            active <= bus.write_data[soc_pkg::FLASH_ACTIVE_BIT];
        end
    end

    // Pin values are only visible while active
    always_ff @(posedge vdp_clk) begin
        if (ctrl_write) begin
            in_q <= bus.write_data[soc_pkg::FLASH_IN_LSB +: NIBBLE_WIDTH];
            in_en_q <= bus.write_data[soc_pkg::FLASH_IN_EN_LSB +: NIBBLE_WIDTH];
            clk_q <= bus.write_data[soc_pkg::FLASH_CLK_BIT];
            csn_q <= bus.write_data[soc_pkg::FLASH_CSN_BIT];
        end
    end

    assign flash_clk = active ? clk_q : 1'b0;
    assign flash_csn = active ? csn_q : 1'b1;
    assign flash_in = active ? in_q : '0;
    assign flash_in_en = active ? in_en_q : '0;

    assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !(flash_clk && flash_csn))
        else $error("flash clock high while chip deselected");

endmodule

//--- src/io_regs.sv
/*
 Status LED register and gamepad latch/clock control.
 The pad serial clocking is done by software through repeated writes.
*/
`timescale 1ns/1ps

module io_regs (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    periph_bus_if.peripheral    bus,
    output soc_pkg::led_t       led,
    output logic                pad_latch,
    output logic                pad_clk
);

    localparam int LED_WIDTH = $bits(soc_pkg::led_t);

    soc_pkg::led_t status;
    logic pad_latch_q;
    logic pad_clk_q;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= '0;
        end else if (bus.write_en && (bus.region == soc_pkg::REGION_STATUS)) begin
            status <= bus.write_data[LED_WIDTH - 1:0];
        end
    end

    // Gamepad control bits
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch_q <= 1'b0;
            pad_clk_q <= 1'b0;
        end else if (bus.write_en && (bus.region == soc_pkg::REGION_PAD)) begin
            pad_latch_q <= bus.write_data[soc_pkg::PAD_LATCH_BIT];
            pad_clk_q <= bus.write_data[soc_pkg::PAD_CLK_BIT];
        end
    end

    assign led = status;
    assign pad_latch = pad_latch_q;
    assign pad_clk = pad_clk_q;

endmodule

//--- src/periph_bus_if.sv
/*
 Decoded access from the address decoder to the peripherals.
 read_en and write_en are single-cycle pulses; the other fields are only
 meaningful in the cycle of a pulse.
*/
`timescale 1ns/1ps

interface periph_bus_if;

    soc_pkg::region_t region;
    logic write_en;
    logic read_en;
    // Selects operand B within the DSP region
    logic operand_b;
    soc_pkg::data_t write_data;

    modport decoder (
        output region,
        output write_en,
        output read_en,
        output operand_b,
        output write_data
    );

    modport peripheral (
        input region,
        input write_en,
        input read_en,
        input operand_b,
        input write_data
    );

endinterface

//--- src/periph_top.sv
/*
 Memory-mapped peripherals in the video clock domain.
 Fixed latency of 2 cycles from the first sampled valid to ready.
 No flash DMA path; the flash pins belong to the bit-bang port alone.
*/
`timescale 1ns/1ps

module periph_top (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    input  logic                cpu_mem_valid,
    input  soc_pkg::addr_t      cpu_address,
    input  soc_pkg::wstrb_t     cpu_wstrb,
    input  soc_pkg::data_t      cpu_write_data,
    input  soc_pkg::pad_data_t  pad_data,
    input  soc_pkg::nibble_t    flash_out,
    output soc_pkg::data_t      cpu_read_data,
    output logic                cpu_mem_ready,
    output soc_pkg::led_t       led,
    output logic                pad_latch,
    output logic                pad_clk,
    output logic                flash_clk,
    output logic                flash_csn,
    output soc_pkg::nibble_t    flash_in,
    output soc_pkg::nibble_t    flash_in_en
);

    soc_pkg::product_t dsp_result;

    periph_bus_if bus ();

    address_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_address(cpu_address),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .cpu_mem_ready(cpu_mem_ready),
        .bus(bus.decoder)
    );

    dsp_mult dsp (
        .vdp_clk(vdp_clk),
        .bus(bus.peripheral),
        .dsp_result(dsp_result)
    );

    io_regs io (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.peripheral),
        .led(led),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk)
    );

    flash_ctrl flash (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.peripheral),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en)
    );

    bus_read_mux read_mux (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.peripheral),
        .dsp_result(dsp_result),
        .pad_data(pad_data),
        .flash_out(flash_out),
        .cpu_read_data(cpu_read_data),
        .cpu_mem_ready(cpu_mem_ready)
    );

endmodule

//--- src/soc_pkg.sv
/*
 Widths, region codes and register bit positions for the peripheral bus.
 Regions are selected by CPU address bits 23:20 only, lower bits are ignored
 except the operand select bit of the DSP region.
*/
package soc_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [15:0] operand_t;
    typedef logic [31:0] product_t;
    typedef logic [7:0]  led_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [1:0]  pad_data_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_STATUS,
        REGION_DSP,
        REGION_PAD,
        REGION_FLASH_CTRL
    } region_t;

    // Values of address bits 23:20
    localparam logic [3:0] REGION_NIBBLE_STATUS = 4'd1;
    localparam logic [3:0] REGION_NIBBLE_DSP    = 4'd2;
    localparam logic [3:0] REGION_NIBBLE_PAD    = 4'd3;
    localparam logic [3:0] REGION_NIBBLE_FLASH  = 4'd4;

    localparam int DSP_OPERAND_B_BIT = 2;

    // Flash control register layout
    localparam int FLASH_IN_LSB     = 0;
    localparam int FLASH_IN_EN_LSB  = 4;
    localparam int FLASH_CLK_BIT    = 8;
    localparam int FLASH_CSN_BIT    = 9;
    localparam int FLASH_ACTIVE_BIT = 15;

    // Gamepad control register layout
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

endpackage

//--- tb.f
src/soc_pkg.sv
src/periph_bus_if.sv
src/address_decoder.sv
src/dsp_mult.sv
src/io_regs.sv
src/flash_ctrl.sv
src/bus_read_mux.sv
src/periph_top.sv
bench/periph_top_tb.sv
